// File: verilog.f
verilog/swu_pkg.sv
verilog/swu_line_buffer.sv
verilog/swu_window_addr.sv
verilog/swu_flow_ctrl.sv
verilog/swu_out_stage.sv
verilog/swu_top.sv
verification/tb_swu.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the result from the simulation output
verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module tb_swu -o tb_swu_sim \
   && ./obj_dir/tb_swu_sim | grep "TESTS PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// File: verification/tb_swu.sv
`timescale 1ns/1ps

module tb_swu;

   localparam int FRAME_OUT       = swu_pkg::OFM_H * swu_pkg::OFM_W * swu_pkg::WINDOW_WORDS;
   localparam int TOTAL_OUT       = 2 * FRAME_OUT;
   localparam int WATCHDOG_CYCLES = 2 * swu_pkg::FRAME_WORDS * swu_pkg::WINDOW_WORDS * 4;
   localparam logic [31:0] SEED   = 32'hfb13_7385;

   logic                       clk;
   logic                       resetn;
   logic [swu_pkg::DATA_W-1:0] in_data_i;
   logic                       in_valid_i;
   logic                       in_ready_o;
   logic [swu_pkg::DATA_W-1:0] out_data_o;
   logic                       out_valid_o;
   logic                       out_ready_i;

   logic [swu_pkg::DATA_W-1:0] frame_mem [2][swu_pkg::FRAME_WORDS];
   logic [31:0]                in_rng;
   int                         out_count;

   swu_top DUT (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // window word n of the whole run, counted over both frames
   function automatic logic [swu_pkg::DATA_W-1:0] expected_word(input int n);
      int f;
      int k;
      int pix;
      int ch;
      int kw;
      int kh;
      int col;
      int row;
      f = n / FRAME_OUT;
      if (f > 1) begin
         f = 1;
      end
      k   = n % FRAME_OUT;
      ch  = k % swu_pkg::EFF_CH;
      kw  = (k / swu_pkg::EFF_CH) % swu_pkg::KERNEL_W;
      kh  = (k / (swu_pkg::EFF_CH * swu_pkg::KERNEL_W)) % swu_pkg::KERNEL_H;
      pix = k / swu_pkg::WINDOW_WORDS;
      col = pix % swu_pkg::OFM_W;
      row = pix / swu_pkg::OFM_W;
      return frame_mem[f][(row * swu_pkg::STRIDE + kh) * swu_pkg::ROW_WORDS
                          + (col * swu_pkg::STRIDE + kw) * swu_pkg::EFF_CH + ch];
   endfunction

   function automatic string test_label(input int n);
      return (n < FRAME_OUT) ? "frame0_backpressure" : "frame1_input_gaps";
   endfunction

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("TESTS FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   // one frame word by word, with a gap chance in percent before each word
   task automatic send_frame(input int f, input int gap_pct);
      int   i;
      logic taken;
      i = 0;
      while (i < swu_pkg::FRAME_WORDS) begin
         in_rng = xorshift(in_rng);
         if ((in_rng % 32'd100) < 32'(gap_pct)) begin
            in_valid_i = 1'b0;
            @(posedge clk);
            #1;
         end else begin
            in_valid_i = 1'b1;
            in_data_i  = frame_mem[f][i];
            taken      = 1'b0;
            while (!taken) begin
               @(negedge clk);
               taken = in_ready_o;
               @(posedge clk);
               #1;
            end
            i++;
         end
      end
      in_valid_i = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////
   // output bookkeeping and checks
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         out_count <= 0;
      end else if (out_valid_o && out_ready_i) begin
         out_count <= out_count + 1;
      end
   end

   assert property (@(posedge clk) $rose(resetn) |-> !out_valid_o && in_ready_o)
      else abort_run("DUT was not idle and ready for input right after reset");

   assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o && out_ready_i |-> out_data_o == expected_word(out_count))
      else abort_run($sformatf("MISMATCH %s expected %h actual %h",
         test_label($sampled(out_count)), expected_word($sampled(out_count)),
         $sampled(out_data_o)));

   assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else abort_run("output word changed or vanished while the sink stalled");

   assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o |-> out_count < TOTAL_OUT)
      else abort_run("DUT produced more output words than two frames hold");

   ////////////////////////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////////////////////////

   initial begin : ready_driver
      logic [31:0] rdy_rng;
      rdy_rng     = SEED ^ 32'h0f0f_0f0f;
      out_ready_i = 1'b0;
      @(posedge resetn);
      forever begin
         @(posedge clk);
         #1;
         rdy_rng     = xorshift(rdy_rng);
         // sink drops ready about one cycle in four
         out_ready_i = rdy_rng[1:0] != 2'b00;
      end
   end

   initial begin : main_seq
      logic [31:0] fill_rng;
      resetn     = 1'b0;
      in_valid_i = 1'b0;
      in_data_i  = '0;
      fill_rng   = SEED;
      for (int f = 0; f < 2; f++) begin
         for (int i = 0; i < swu_pkg::FRAME_WORDS; i++) begin
            fill_rng        = xorshift(fill_rng);
            frame_mem[f][i] = fill_rng[swu_pkg::DATA_W-1:0];
         end
      end
      in_rng = xorshift(fill_rng);
      repeat (3) @(posedge clk);
      #1;
      resetn = 1'b1;
      // frame 0 back to back, frame 1 with holes in the input stream
      send_frame(0, 0);
      send_frame(1, 30);
      while (out_count < TOTAL_OUT) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);
      if (out_count == TOTAL_OUT) begin
         $display("TESTS PASSED");
         $finish;
      end else begin
         abort_run("output word count after both frames is wrong");
      end
   end

   initial begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run("watchdog expired before all window words came out");
   end

endmodule

// File: verilog/swu_top.sv
`timescale 1ns/1ps

module swu_top (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::DATA_W-1:0] in_data_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   output logic [swu_pkg::DATA_W-1:0] out_data_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i
);

   logic                          wr_en;
   logic                          rd_en;
   logic                          row_done;
   logic                          frame_last_rd;
   logic                          out_space;
   logic [swu_pkg::ADDR_W-1:0]    rd_addr;
   logic [swu_pkg::ROW_CNT_W-1:0] rd_row_need;
   logic [swu_pkg::DATA_W-1:0]    rd_data;

   swu_flow_ctrl u_flow_ctrl (
      .clk             (clk),
      .resetn          (resetn),
      .in_valid_i      (in_valid_i),
      .in_ready_o      (in_ready_o),
      .wr_en_o         (wr_en),
      .rd_row_need_i   (rd_row_need),
      .row_done_i      (row_done),
      .frame_last_rd_i (frame_last_rd),
      .out_space_i     (out_space),
      .rd_en_o         (rd_en)
   );

   swu_line_buffer u_line_buffer (
      .clk       (clk),
      .resetn    (resetn),
      .wr_en_i   (wr_en),
      .wr_data_i (in_data_i),
      .rd_en_i   (rd_en),
      .rd_addr_i (rd_addr),
      .rd_data_o (rd_data)
   );

   swu_window_addr u_window_addr (
      .clk             (clk),
      .resetn          (resetn),
      .rd_en_i         (rd_en),
      .rd_addr_o       (rd_addr),
      .rd_row_need_o   (rd_row_need),
      .row_done_o      (row_done),
      .frame_last_rd_o (frame_last_rd)
   );

   swu_out_stage u_out_stage (
      .clk         (clk),
      .resetn      (resetn),
      .rd_en_i     (rd_en),
      .rd_data_i   (rd_data),
      .out_space_o (out_space),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// File: verilog/swu_out_stage.sv
`timescale 1ns/1ps

module swu_out_stage (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       rd_en_i,
   input  logic [swu_pkg::DATA_W-1:0] rd_data_i,
   output logic                       out_space_o,
   output logic [swu_pkg::DATA_W-1:0] out_data_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i
);

   // r follows the buffer read, q drives the port, s catches a word during a stall
   logic                       r_valid;
   logic                       q_valid;
   logic                       s_valid;
   logic [swu_pkg::DATA_W-1:0] q_data;
   logic [swu_pkg::DATA_W-1:0] s_data;
   logic                       pop;
   logic                       q_free;
   logic                       q_load_s;
   logic                       q_load_r;
   logic                       s_load;
   logic [1:0]                 held;

   assign pop      = q_valid && out_ready_i;
   assign q_free   = !q_valid || out_ready_i;
   assign q_load_s = q_free && s_valid;
   assign q_load_r = q_free && !s_valid && r_valid;
   assign s_load   = r_valid && (s_valid == q_free);

   // words held plus the one in flight, minus what leaves this cycle
   assign held        = 2'(q_valid) + 2'(s_valid) + 2'(r_valid) - 2'(pop);
   assign out_space_o = held < 2'd2;
   assign out_valid_o = q_valid;
   assign out_data_o  = q_data;

   always_ff @(posedge clk) begin
      if (!resetn) begin
         r_valid <= 1'b0;
         q_valid <= 1'b0;
         s_valid <= 1'b0;
      end else begin
         r_valid <= rd_en_i;
         if (q_free) begin
            q_valid <= s_valid || r_valid;
         end
         if (q_load_s) begin
            s_valid <= r_valid;
         end else if (s_load) begin
            s_valid <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (q_load_s) begin
         q_data <= s_data;
      end else if (q_load_r) begin
         q_data <= rd_data_i;
      end
      if (s_load) begin
         s_data <= rd_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   assert property (@(posedge clk) disable iff (!resetn)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
      else $error("output word changed while stalled");

endmodule

// File: verilog/swu_flow_ctrl.sv
`timescale 1ns/1ps

module swu_flow_ctrl (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          in_valid_i,
   output logic                          in_ready_o,
   output logic                          wr_en_o,
   input  logic [swu_pkg::ROW_CNT_W-1:0] rd_row_need_i,
   input  logic                          row_done_i,
   input  logic                          frame_last_rd_i,
   input  logic                          out_space_i,
   output logic                          rd_en_o
);

   logic [swu_pkg::WORD_CNT_W-1:0] wr_word;
   logic [swu_pkg::ROW_CNT_W-1:0]  rows_done;
   logic [swu_pkg::ROW_CNT_W-1:0]  oldest_row;
   logic [swu_pkg::ROW_CNT_W:0]    wr_limit;
   logic                           rd_drain;
   logic                           frame_written;
   logic                           row_end;
   logic                           restart;

   assign frame_written = rows_done == swu_pkg::ROW_CNT_W'(swu_pkg::IFM_H);
   // both sides of the frame are finished
   assign restart       = frame_written && rd_drain;

   // the row being written may reuse a slot only once its old row is no longer needed
   assign wr_limit   = {1'b0, oldest_row} + (swu_pkg::ROW_CNT_W+1)'(swu_pkg::BUF_ROWS);
   assign in_ready_o = !frame_written && ({1'b0, rows_done} < wr_limit);
   assign wr_en_o    = in_valid_i && in_ready_o;
   assign row_end    = wr_en_o && (wr_word == swu_pkg::WORD_CNT_W'(swu_pkg::ROW_WORDS - 1));

   assign rd_en_o = out_space_i && !rd_drain && (rd_row_need_i < rows_done);

   always_ff @(posedge clk) begin
      if (!resetn || restart) begin
         wr_word    <= '0;
         rows_done  <= '0;
         oldest_row <= '0;
         rd_drain   <= 1'b0;
      end else begin
         if (wr_en_o) begin
            wr_word <= row_end ? '0 : wr_word + 1'b1;
         end
         if (row_end) begin
            rows_done <= rows_done + 1'b1;
         end
         // an output row is done so its first STRIDE input rows are free
         if (row_done_i) begin
            oldest_row <= oldest_row + swu_pkg::ROW_CNT_W'(swu_pkg::STRIDE);
         end
         if (frame_last_rd_i) begin
            rd_drain <= 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // a granted read only addresses input rows that are still held
   assert property (@(posedge clk) disable iff (!resetn)
      rd_en_o |-> rd_row_need_i >= oldest_row)
      else $error("read addressed an input row that has already left the buffer");

endmodule

// File: verilog/swu_window_addr.sv
`timescale 1ns/1ps

module swu_window_addr (
   input  logic                          clk,
   input  logic                          resetn,
   input  logic                          rd_en_i,
   output logic [swu_pkg::ADDR_W-1:0]    rd_addr_o,
   output logic [swu_pkg::ROW_CNT_W-1:0] rd_row_need_o,
   output logic                          row_done_o,
   output logic                          frame_last_rd_o
);

   logic [swu_pkg::CH_W-1:0]   ch;
   logic [swu_pkg::KW_W-1:0]   kw;
   logic [swu_pkg::KH_W-1:0]   kh;
   logic [swu_pkg::COL_W-1:0]  out_col;
   logic [swu_pkg::ROW_W-1:0]  out_row;
   // buffer address of input row out_row*STRIDE
   logic [swu_pkg::ADDR_W-1:0] row_base;
   // buffer address of the top-left word of the current window
   logic [swu_pkg::ADDR_W-1:0] pix_base;
   logic [swu_pkg::ADDR_W-1:0] next_row_base;
   logic [swu_pkg::ADDR_W:0]   win_off;
   logic [swu_pkg::ADDR_W:0]   row_step;
   logic                       ch_last;
   logic                       kw_last;
   logic                       kh_last;
   logic                       col_last;
   logic                       row_last;
   logic                       pix_done;

   // both operands stay below BUF_DEPTH so one subtraction wraps
   function automatic logic [swu_pkg::ADDR_W-1:0] wrap_add(
      input logic [swu_pkg::ADDR_W-1:0] base,
      input logic [swu_pkg::ADDR_W:0]   step
   );
      logic [swu_pkg::ADDR_W:0] sum;
      sum = {1'b0, base} + step;
      if (sum >= (swu_pkg::ADDR_W+1)'(swu_pkg::BUF_DEPTH)) begin
         sum = sum - (swu_pkg::ADDR_W+1)'(swu_pkg::BUF_DEPTH);
      end
      return sum[swu_pkg::ADDR_W-1:0];
   endfunction

   assign ch_last  = ch == swu_pkg::CH_W'(swu_pkg::EFF_CH - 1);
   assign kw_last  = kw == swu_pkg::KW_W'(swu_pkg::KERNEL_W - 1);
   assign kh_last  = kh == swu_pkg::KH_W'(swu_pkg::KERNEL_H - 1);
   assign col_last = out_col == swu_pkg::COL_W'(swu_pkg::OFM_W - 1);
   assign row_last = out_row == swu_pkg::ROW_W'(swu_pkg::OFM_H - 1);

   assign pix_done        = rd_en_i && ch_last && kw_last && kh_last;
   assign row_done_o      = pix_done && col_last;
   assign frame_last_rd_o = row_done_o && row_last;

   // kernel row, then column, then channel group
   assign win_off = (swu_pkg::ADDR_W+1)'(kh) * (swu_pkg::ADDR_W+1)'(swu_pkg::ROW_WORDS)
                  + (swu_pkg::ADDR_W+1)'(kw) * (swu_pkg::ADDR_W+1)'(swu_pkg::EFF_CH)
                  + (swu_pkg::ADDR_W+1)'(ch);
   assign rd_addr_o = wrap_add(pix_base, win_off);

   assign rd_row_need_o = swu_pkg::ROW_CNT_W'(out_row) * swu_pkg::ROW_CNT_W'(swu_pkg::STRIDE)
                        + swu_pkg::ROW_CNT_W'(kh);

   // the last output row jumps over the unused rows to the next frame
   assign row_step = row_last ? (swu_pkg::ADDR_W+1)'(swu_pkg::FRAME_STEP)
                              : (swu_pkg::ADDR_W+1)'(swu_pkg::ROW_STEP);
   assign next_row_base = wrap_add(row_base, row_step);

   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch       <= '0;
         kw       <= '0;
         kh       <= '0;
         out_col  <= '0;
         out_row  <= '0;
         row_base <= '0;
         pix_base <= '0;
      end else if (rd_en_i) begin
         ch <= ch_last ? '0 : ch + 1'b1;
         if (ch_last) begin
            kw <= kw_last ? '0 : kw + 1'b1;
            if (kw_last) begin
               kh <= kh_last ? '0 : kh + 1'b1;
            end
         end
         if (pix_done) begin
            if (col_last) begin
               out_col  <= '0;
               out_row  <= row_last ? '0 : out_row + 1'b1;
               row_base <= next_row_base;
               pix_base <= next_row_base;
            end else begin
               out_col  <= out_col + 1'b1;
               pix_base <= wrap_add(pix_base, (swu_pkg::ADDR_W+1)'(swu_pkg::PIX_STEP));
            end
         end
      end
   end

endmodule

// File: verilog/swu_line_buffer.sv
`timescale 1ns/1ps

module swu_line_buffer (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       wr_en_i,
   input  logic [swu_pkg::DATA_W-1:0] wr_data_i,
   input  logic                       rd_en_i,
   input  logic [swu_pkg::ADDR_W-1:0] rd_addr_i,
   output logic [swu_pkg::DATA_W-1:0] rd_data_o
);

   logic [swu_pkg::DATA_W-1:0] mem [swu_pkg::BUF_DEPTH];
   logic [swu_pkg::ADDR_W-1:0] wr_ptr;

   // write pointer runs on across frames
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_ptr <= '0;
      end else if (wr_en_i) begin
         if (wr_ptr == swu_pkg::ADDR_W'(swu_pkg::BUF_DEPTH - 1)) begin
            wr_ptr <= '0;
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_ptr] <= wr_data_i;
      end
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

   ////////////////////////////////////////////////////////////
   // checks
   ////////////////////////////////////////////////////////////

   // a granted write must never hit the buffer row that is being read
   assert property (@(posedge clk) disable iff (!resetn)
      wr_en_i && rd_en_i |->
         (wr_ptr / swu_pkg::ROW_WORDS) != (rd_addr_i / swu_pkg::ROW_WORDS))
      else $error("write landed on a buffer row that is still read");

endmodule

// File: verilog/swu_pkg.sv
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // feature-map geometry
   ////////////////////////////////////////////////////////////
   localparam int SIMD     = 2;
   localparam int IP_PREC  = 8;
   localparam int IFM_CH   = 4;
   localparam int IFM_W    = 9;
   localparam int IFM_H    = 7;
   localparam int KERNEL_H = 3;
   localparam int KERNEL_W = 3;
   localparam int STRIDE   = 2;

   // derived sizes, all counted in words
   localparam int EFF_CH       = IFM_CH / SIMD;
   localparam int OFM_W        = (IFM_W - KERNEL_W) / STRIDE + 1;
   localparam int OFM_H        = (IFM_H - KERNEL_H) / STRIDE + 1;
   localparam int ROW_WORDS    = IFM_W * EFF_CH;
   localparam int BUF_ROWS     = KERNEL_H + STRIDE;
   localparam int BUF_DEPTH    = BUF_ROWS * ROW_WORDS;
   localparam int FRAME_WORDS  = IFM_H * ROW_WORDS;
   localparam int WINDOW_WORDS = KERNEL_H * KERNEL_W * EFF_CH;

   // start-position steps inside the circular buffer
   localparam int PIX_STEP   = STRIDE * EFF_CH;
   localparam int ROW_STEP   = STRIDE * ROW_WORDS;
   // from the last output row's first input row to the next frame's row 0
   localparam int FRAME_STEP = (IFM_H - (OFM_H - 1) * STRIDE) * ROW_WORDS;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////
   localparam int DATA_W     = SIMD * IP_PREC;
   localparam int ADDR_W     = $clog2(BUF_DEPTH);
   localparam int ROW_CNT_W  = $clog2(IFM_H + 2);
   localparam int WORD_CNT_W = $clog2(ROW_WORDS + 1);
   localparam int CH_W       = $clog2(EFF_CH + 1);
   localparam int KW_W       = $clog2(KERNEL_W + 1);
   localparam int KH_W       = $clog2(KERNEL_H + 1);
   localparam int COL_W      = $clog2(OFM_W + 1);
   localparam int ROW_W      = $clog2(OFM_H + 1);

endpackage
